/* blasLane.f */
+incdir+.
blasLanePkg.sv
ringBuffCtrl.sv
fMltUnit.sv
fAddUnit.sv
laneDispatch.sv
resultMerge.sv
blasLaneTop.sv
blasLane_props.sv
blasLaneTb.sv

/* blasLanePkg.sv */
// BLAS lane package
// Vector types, bus and result structs, dispatcher states

`include "blasLane_settings.svh"

package blasLanePkg;

	//////////////////////////////
	// Plain vectors
	//////////////////////////////
	typedef logic [`DATA_WIDTH-1:0]				data_t;
	typedef logic [`TAG_WIDTH-1:0]				tag_t;
	typedef logic [`WB_ADR_WIDTH-1:0]			wbAdr_t;
	typedef logic [$clog2(`RESULT_DEPTH+1)-1:0]	qCount_t;		// Result queue occupancy

	//////////////////////////////
	// Structs
	//////////////////////////////
	typedef struct packed {
		logic	valid;		// Issue strobe
		tag_t	tag;
	} unitCmd_t;

	typedef struct packed {
		data_t	data;
		tag_t	tag;
	} laneResult_t;

	typedef struct packed {
		logic	cyc;
		logic	stb;
		logic	we;
		wbAdr_t	adr;
		data_t	dat;		// Write data
	} wbReq_t;

	typedef struct packed {
		logic	ack;
		data_t	dat;		// Read data
	} wbRsp_t;

	// Dispatcher FSM
	typedef enum logic [1:0] {
		idle,
		issue,		// Waiting for room in the unit pipe
		respond
	} dispState_t;

endpackage

/* blasLaneTb.sv */
// BLAS lane testbench
// Drives the Wishbone port, keeps the expected result per tag and checks readback

`timescale 1ns/1ns

`include "blasLane_settings.svh"

module blasLaneTb;

	localparam int ackLimit		= 50;		// Cycles allowed per bus access
	localparam int pollLimit	= 100;		// Status reads allowed per wait
	localparam int numTags		= 2 ** `TAG_WIDTH;

	localparam blasLanePkg::wbAdr_t adrOpA		= `WB_ADR_WIDTH'(0);
	localparam blasLanePkg::wbAdr_t adrOpB		= `WB_ADR_WIDTH'(1);
	localparam blasLanePkg::wbAdr_t adrCmd		= `WB_ADR_WIDTH'(2);
	localparam blasLanePkg::wbAdr_t adrResult	= `WB_ADR_WIDTH'(3);
	localparam blasLanePkg::wbAdr_t adrStatus	= `WB_ADR_WIDTH'(4);

	logic					clock;
	logic					reset;
	blasLanePkg::wbReq_t	wbReq;
	blasLanePkg::wbRsp_t	wbRsp;

	integer					seed;
	string					testName;
	int						testErrors;
	int						errorCount;
	int						testCount;
	int						failedTests;
	int						cycles;
	int						floodCount;
	blasLanePkg::data_t		rdWord;

	// Scoreboard, indexed by tag
	blasLanePkg::data_t		expected [numTags];
	logic					pending [numTags];
	logic					isAddOf [numTags];
	blasLanePkg::tag_t		mltOrder [$];
	blasLanePkg::tag_t		addOrder [$];

	blasLaneTop dut0 (
		.clock	(clock),
		.reset	(reset),
		.wbReq	(wbReq),
		.wbRsp	(wbRsp)
	);

	always #20 clock = ~clock;

	//////////////////////////////
	// Bus access
	//////////////////////////////
	task automatic abortRun(input string why);
		$display("%s: %s", testName, why);
		$display("Test failures found");
		$finish;
	endtask

	task automatic writeReg(input blasLanePkg::wbAdr_t adr, input blasLanePkg::data_t dat,
			output int waited);
		waited = 0;
		@(negedge clock);
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		do begin
			@(negedge clock);
			waited++;
		end while (!wbRsp.ack && waited < ackLimit);
		wbReq = '0;
		if (!wbRsp.ack)
			abortRun("no ack on a register write");
	endtask

	task automatic readReg(input blasLanePkg::wbAdr_t adr, output blasLanePkg::data_t dat,
			output int waited);
		waited = 0;
		dat = '0;
		@(negedge clock);
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
		do begin
			@(negedge clock);
			waited++;
		end while (!wbRsp.ack && waited < ackLimit);
		dat = wbRsp.dat;
		wbReq = '0;
		if (!wbRsp.ack)
			abortRun("no ack on a register read");
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////
	task automatic expectEqual(input string what, input blasLanePkg::data_t exp,
			input blasLanePkg::data_t act);
		assert (exp === act) else begin
			$display("mismatch %s %s: expected %h, actual %h", testName, what, exp, act);
			testErrors++;
		end
	endtask

	task automatic expectTrue(input logic cond, input string why);
		assert (cond) else begin
			$display("%s: %s", testName, why);
			testErrors++;
		end
	endtask

	task automatic closeTest();
		testCount++;
		errorCount += testErrors;
		if (testErrors != 0)
			failedTests++;
		$display("%s: %s (%0d errors)", testName, (testErrors == 0) ? "ok" : "failed", testErrors);
		testErrors = 0;
	endtask

	//////////////////////////////
	// Operations
	//////////////////////////////
	// Expected value from the full-width result, cut to 32 bits
	task automatic loadOperands(input logic isAdd, input blasLanePkg::tag_t tag);
		blasLanePkg::data_t a;
		blasLanePkg::data_t b;
		logic [63:0] wide;
		int waited;
		a = $random(seed);
		b = $random(seed);
		writeReg(adrOpA, a, waited);
		writeReg(adrOpB, b, waited);
		wide = isAdd ? ({32'd0, a} + {32'd0, b}) : ({32'd0, a} * {32'd0, b});
		expected[tag] = wide[31:0];
	endtask

	task automatic issueCmd(input logic isAdd, input blasLanePkg::tag_t tag, output int waited);
		writeReg(adrCmd, {23'd0, isAdd, tag}, waited);		// Bit 8 selects add
		pending[tag] = 1'b1;
		isAddOf[tag] = isAdd;
		if (isAdd)
			addOrder.push_back(tag);
		else
			mltOrder.push_back(tag);
	endtask

	task automatic issueOp(input logic isAdd, input blasLanePkg::tag_t tag, output int waited);
		loadOperands(isAdd, tag);
		issueCmd(isAdd, tag, waited);
	endtask

	task automatic waitForCount(input int target);
		blasLanePkg::data_t status;
		int polls;
		int waited;
		polls = 0;
		do begin
			readReg(adrStatus, status, waited);
			polls++;
		end while (int'(status[15:8]) < target && polls < pollLimit);
		if (int'(status[15:8]) < target)
			abortRun("result queue never reached the expected count");
	endtask

	// Status gives the head tag, the result read pops it
	task automatic drainOne();
		blasLanePkg::data_t status;
		blasLanePkg::data_t data;
		blasLanePkg::tag_t tag;
		blasLanePkg::tag_t nextTag;
		int waited;
		readReg(adrStatus, status, waited);
		tag = status[7:0];
		readReg(adrResult, data, waited);
		expectTrue(status[15:8] != 8'd0, "status showed an empty queue before a pop");
		expectTrue(pending[tag], "result came back under a tag that was not outstanding");
		expectEqual("value", expected[tag], data);
		nextTag = ~tag;
		if (isAddOf[tag]) begin
			if (addOrder.size() != 0)
				nextTag = addOrder.pop_front();
		end else begin
			if (mltOrder.size() != 0)
				nextTag = mltOrder.pop_front();
		end
		expectEqual("order", {24'd0, nextTag}, {24'd0, tag});
		pending[tag] = 1'b0;
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		seed		= 32'h1f864f7f;
		clock		= 1'b0;
		reset		= 1'b1;
		wbReq		= '0;
		testName	= "reset";
		testErrors	= 0;
		errorCount	= 0;
		testCount	= 0;
		failedTests	= 0;
		floodCount	= `RESULT_DEPTH + `PIPE_DEPTH;		// Queue plus one unit pipe
		for (int i = 0; i < numTags; i++) begin
			pending[i] = 1'b0;
			isAddOf[i] = 1'b0;
		end
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		testName = "resetStatus";
		readReg(adrStatus, rdWord, cycles);
		expectEqual("count", 32'd0, {24'd0, rdWord[15:8]});
		closeTest();

		testName = "multiply";
		issueOp(1'b0, 8'h11, cycles);
		waitForCount(1);
		drainOne();
		closeTest();

		testName = "add";
		issueOp(1'b1, 8'h22, cycles);
		waitForCount(1);
		drainOne();
		closeTest();

		testName = "interleaved";
		for (int i = 0; i < 8; i++)
			issueOp(i[0], 8'h40 + 8'(i), cycles);
		waitForCount(8);
		for (int i = 0; i < 8; i++)
			drainOne();
		closeTest();

		// Fill the queue and the add pipe, then pop one and issue into the full pipe
		testName = "backPressure";
		for (int i = 0; i < floodCount; i++) begin
			issueOp(1'b1, 8'h80 + 8'(i), cycles);
			expectTrue(cycles == 1, "command ack came late while the pipe had room");
		end
		waitForCount(`RESULT_DEPTH);
		loadOperands(1'b1, 8'hc0);
		drainOne();
		issueCmd(1'b1, 8'hc0, cycles);
		expectTrue(cycles > 1, "command ack was not held back with the add pipe full");
		for (int i = 0; i < floodCount; i++) begin
			waitForCount(1);
			drainOne();
		end
		readReg(adrStatus, rdWord, cycles);
		expectEqual("final count", 32'd0, {24'd0, rdWord[15:8]});
		expectTrue(mltOrder.size() == 0 && addOrder.size() == 0,
			"some issued results never came back");
		closeTest();

		$display("%0d tests run, %0d failed, %0d failed checks", testCount, failedTests,
			errorCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* blasLaneTop.sv */
// BLAS execution lane
// Wishbone dispatcher, multiply and add units, result merger

`timescale 1ns/1ns

module blasLaneTop (
	input  logic					clock,
	input  logic					reset,
	input  blasLanePkg::wbReq_t		wbReq,
	output blasLanePkg::wbRsp_t		wbRsp
);

	// Dispatcher to units
	logic						mltEnable;
	logic						addEnable;
	blasLanePkg::data_t			operandA;
	blasLanePkg::data_t			operandB;
	blasLanePkg::unitCmd_t		cmd;
	logic						mltFull;
	logic						addFull;

	// Units to merger
	logic						mltValid;
	logic						addValid;
	logic						mltStall;
	logic						addStall;
	blasLanePkg::laneResult_t	mltResult;
	blasLanePkg::laneResult_t	addResult;

	// Queue readback
	blasLanePkg::laneResult_t	head;
	blasLanePkg::qCount_t		count;
	logic						pop;

	laneDispatch dispatch0 (
		.clock		(clock),
		.reset		(reset),
		.wbReq		(wbReq),
		.wbRsp		(wbRsp),
		.mltEnable	(mltEnable),
		.addEnable	(addEnable),
		.operandA	(operandA),
		.operandB	(operandB),
		.cmd		(cmd),
		.mltFull	(mltFull),
		.addFull	(addFull),
		.head		(head),
		.count		(count),
		.pop		(pop)
	);

	fMltUnit mltUnit0 (
		.clock		(clock),
		.reset		(reset),
		.enable		(mltEnable),
		.stall		(mltStall),
		.operandA	(operandA),
		.operandB	(operandB),
		.cmd		(cmd),
		.valid		(mltValid),
		.result		(mltResult),
		.full		(mltFull)
	);

	fAddUnit addUnit0 (
		.clock		(clock),
		.reset		(reset),
		.enable		(addEnable),
		.stall		(addStall),
		.operandA	(operandA),
		.operandB	(operandB),
		.cmd		(cmd),
		.valid		(addValid),
		.result		(addResult),
		.full		(addFull)
	);

	resultMerge merge0 (
		.clock		(clock),
		.reset		(reset),
		.mltValid	(mltValid),
		.mltResult	(mltResult),
		.addValid	(addValid),
		.addResult	(addResult),
		.pop		(pop),
		.mltStall	(mltStall),
		.addStall	(addStall),
		.head		(head),
		.count		(count)
	);

endmodule

/* blasLane_props.sv */
// Lane protocol properties
// Wishbone ack rules and reset state, bound into the lane top

`timescale 1ns/1ns

module blasLaneProps (
	input  logic					clock,
	input  logic					reset,
	input  blasLanePkg::wbReq_t		wbReq,
	input  blasLanePkg::wbRsp_t		wbRsp,
	input  logic					mltValid,
	input  logic					addValid,
	input  logic					mltStall,
	input  logic					addStall,
	input  logic					pop,
	input  blasLanePkg::qCount_t	count
);

	logic request;

	assign request = wbReq.cyc & wbReq.stb;

	// Ack answers a request that was held on the previous edge
	ackNeedsRequest: assert property (@(posedge clock) disable iff (reset)
		wbRsp.ack |-> $past(request))
		else $error("ack raised without a pending request");

	ackOnePulse: assert property (@(posedge clock) disable iff (reset)
		wbRsp.ack |=> !wbRsp.ack)
		else $error("ack held for two cycles");

	//////////////////////////////
	// Reset state
	//////////////////////////////
	unitsQuietInReset: assert property (@(posedge clock)
		reset |=> (!mltValid && !addValid && !mltStall && !addStall))
		else $error("unit valid or stall active during reset");

	busQuietInReset: assert property (@(posedge clock)
		reset |=> (!wbRsp.ack && !pop && count == '0))
		else $error("ack, pop or queue count not cleared by reset");

endmodule

bind blasLaneTop blasLaneProps props0 (
	.clock		(clock),
	.reset		(reset),
	.wbReq		(wbReq),
	.wbRsp		(wbRsp),
	.mltValid	(mltValid),
	.addValid	(addValid),
	.mltStall	(mltStall),
	.addStall	(addStall),
	.pop		(pop),
	.count		(count)
);

/* blasLane_settings.svh */
// BLAS lane settings
// Widths and depths shared by the lane RTL

`ifndef BLASLANE_SETTINGS_SVH
`define BLASLANE_SETTINGS_SVH

// Datapath
`define DATA_WIDTH		32		// Operand and result width
`define TAG_WIDTH		8		// Host chosen command tag

// Buffering
`define PIPE_DEPTH		4		// Entries per unit pipe
`define RESULT_DEPTH	8		// Entries in the result queue

// Host bus
`define WB_ADR_WIDTH	3		// Word address width

`endif

/* fAddUnit.sv */
// Add unit
// Unsigned sum modulo 2^32, parked with its tag in a ring pipe

`timescale 1ns/1ns

`include "blasLane_settings.svh"

module fAddUnit (
	input  logic						clock,
	input  logic						reset,
	input  logic						enable,		// Unit selected for this issue
	input  logic						stall,
	input  blasLanePkg::data_t			operandA,
	input  blasLanePkg::data_t			operandB,
	input  blasLanePkg::unitCmd_t		cmd,
	output logic						valid,
	output blasLanePkg::laneResult_t	result,
	output logic						full
);

	localparam int ptrWidth = $clog2(`PIPE_DEPTH);

	blasLanePkg::data_t			sum;
	logic						we;
	logic						re;
	logic						empty;
	logic [ptrWidth-1:0]		wAddr;
	logic [ptrWidth-1:0]		rAddr;

	blasLanePkg::laneResult_t	pipeMem [`PIPE_DEPTH];

	assign sum = operandA + operandB;		// Carry out dropped

	assign we = enable & cmd.valid & ~full;
	assign re = ~empty & ~stall;

	always_ff @(posedge clock) begin
		if (we)
			pipeMem[wAddr] <= '{data: sum, tag: cmd.tag};
	end

	assign valid	= re;
	assign result	= pipeMem[rAddr];

	// Pointer bookkeeping
	ringBuffCtrl #(
		.numEntry	(`PIPE_DEPTH)
	) pipeCtrl (
		.clock		(clock),
		.reset		(reset),
		.we			(we),
		.re			(re),
		.wAddr		(wAddr),
		.rAddr		(rAddr),
		.full		(full),
		.empty		(empty),
		.count		()
	);

endmodule

/* fMltUnit.sv */
// Multiply unit
// Unsigned product truncated to the data width, parked with its tag in a ring pipe

`timescale 1ns/1ns

`include "blasLane_settings.svh"

module fMltUnit (
	input  logic						clock,
	input  logic						reset,
	input  logic						enable,		// Unit selected for this issue
	input  logic						stall,		// Back-pressure from the merger
	input  blasLanePkg::data_t			operandA,
	input  blasLanePkg::data_t			operandB,
	input  blasLanePkg::unitCmd_t		cmd,
	output logic						valid,
	output blasLanePkg::laneResult_t	result,
	output logic						full
);

	localparam int ptrWidth = $clog2(`PIPE_DEPTH);

	blasLanePkg::data_t			product;
	logic						we;
	logic						re;
	logic						empty;
	logic [ptrWidth-1:0]		wAddr;
	logic [ptrWidth-1:0]		rAddr;

	blasLanePkg::laneResult_t	pipeMem [`PIPE_DEPTH];

	// Low half of the product only
	assign product = operandA * operandB;

	assign we = enable & cmd.valid & ~full;
	assign re = ~empty & ~stall;

	//////////////////////////////
	// Result pipe
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (we)
			pipeMem[wAddr] <= '{data: product, tag: cmd.tag};
	end

	// Head entry goes out whenever released
	assign valid	= re;
	assign result	= pipeMem[rAddr];

	ringBuffCtrl #(
		.numEntry	(`PIPE_DEPTH)
	) pipeCtrl (
		.clock		(clock),
		.reset		(reset),
		.we			(we),
		.re			(re),
		.wAddr		(wAddr),
		.rAddr		(rAddr),
		.full		(full),
		.empty		(empty),
		.count		()
	);

endmodule

/* laneDispatch.sv */
// Lane dispatcher
// Wishbone classic slave for operands, commands, status and result readback

`timescale 1ns/1ns

`include "blasLane_settings.svh"

module laneDispatch (
	input  logic						clock,
	input  logic						reset,
	input  blasLanePkg::wbReq_t			wbReq,
	output blasLanePkg::wbRsp_t			wbRsp,
	output logic						mltEnable,
	output logic						addEnable,
	output blasLanePkg::data_t			operandA,
	output blasLanePkg::data_t			operandB,
	output blasLanePkg::unitCmd_t		cmd,
	input  logic						mltFull,
	input  logic						addFull,
	input  blasLanePkg::laneResult_t	head,
	input  blasLanePkg::qCount_t		count,
	output logic						pop
);

	// Register map, word addresses
	localparam blasLanePkg::wbAdr_t adrOpA		= `WB_ADR_WIDTH'(0);
	localparam blasLanePkg::wbAdr_t adrOpB		= `WB_ADR_WIDTH'(1);
	localparam blasLanePkg::wbAdr_t adrCmd		= `WB_ADR_WIDTH'(2);
	localparam blasLanePkg::wbAdr_t adrResult	= `WB_ADR_WIDTH'(3);
	localparam blasLanePkg::wbAdr_t adrStatus	= `WB_ADR_WIDTH'(4);

	blasLanePkg::dispState_t	state;
	blasLanePkg::dispState_t	nextState;

	logic						request;
	logic						accept;			// Request taken in idle
	logic						reqCmd;
	logic						reqFull;
	logic						selFull;
	logic						issueNow;
	logic						opSel;			// 0 multiply, 1 add
	logic						accCmd;
	logic						popPending;
	blasLanePkg::tag_t			cmdTag;
	blasLanePkg::data_t			rdData;
	blasLanePkg::data_t			statusWord;

	assign request	= wbReq.cyc & wbReq.stb;
	assign accept	= (state == blasLanePkg::idle) & request;
	assign reqCmd	= request & wbReq.we & (wbReq.adr == adrCmd);
	assign reqFull	= wbReq.dat[8] ? addFull : mltFull;		// Target of the incoming command
	assign selFull	= opSel ? addFull : mltFull;			// Target of the held command

	// Count in 15:8, head tag in 7:0
	assign statusWord = {16'd0, 8'(count), head.tag};

	//////////////////////////////
	// FSM
	//////////////////////////////
	always_comb begin
		nextState = state;
		case (state)
			blasLanePkg::idle: begin
				if (request)
					nextState = (reqCmd && reqFull) ? blasLanePkg::issue : blasLanePkg::respond;
			end
			blasLanePkg::issue: begin
				if (!selFull)
					nextState = blasLanePkg::respond;
			end
			blasLanePkg::respond:	nextState = blasLanePkg::idle;
			default:				nextState = blasLanePkg::idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= blasLanePkg::idle;
			accCmd		<= 1'b0;
			popPending	<= 1'b0;
			opSel		<= 1'b0;
		end else begin
			state <= nextState;
			if (accept) begin
				accCmd		<= reqCmd;
				// Pop only what was actually read back
				popPending	<= ~wbReq.we & (wbReq.adr == adrResult) & (count != '0);
				if (reqCmd)
					opSel <= wbReq.dat[8];
			end
		end
	end

	//////////////////////////////
	// Data registers
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (accept) begin
			if (wbReq.we) begin
				case (wbReq.adr)
					adrOpA:		operandA	<= wbReq.dat;
					adrOpB:		operandB	<= wbReq.dat;
					adrCmd:		cmdTag		<= wbReq.dat[`TAG_WIDTH-1:0];
					default:	;
				endcase
			end else begin
				case (wbReq.adr)
					adrResult:	rdData <= head.data;
					adrStatus:	rdData <= statusWord;
					default:	rdData <= '0;		// Write-only registers
				endcase
			end
		end
	end

	// Issue happens in the ack cycle
	assign issueNow		= (state == blasLanePkg::respond) & accCmd;
	assign cmd			= '{valid: issueNow, tag: cmdTag};
	assign mltEnable	= issueNow & ~opSel;
	assign addEnable	= issueNow & opSel;
	assign pop			= (state == blasLanePkg::respond) & popPending;

	assign wbRsp = '{ack: (state == blasLanePkg::respond), dat: rdData};

endmodule

/* resultMerge.sv */
// Result merger
// Fixed-priority merge of unit results into the result queue, multiply first

`timescale 1ns/1ns

`include "blasLane_settings.svh"

module resultMerge (
	input  logic						clock,
	input  logic						reset,
	input  logic						mltValid,
	input  blasLanePkg::laneResult_t	mltResult,
	input  logic						addValid,
	input  blasLanePkg::laneResult_t	addResult,
	input  logic						pop,
	output logic						mltStall,
	output logic						addStall,
	output blasLanePkg::laneResult_t	head,
	output blasLanePkg::qCount_t		count
);

	localparam int ptrWidth = $clog2(`RESULT_DEPTH);

	logic						push;
	logic						popQ;
	logic						full;
	logic						empty;
	logic [ptrWidth-1:0]		wAddr;
	logic [ptrWidth-1:0]		rAddr;
	blasLanePkg::laneResult_t	pushData;

	blasLanePkg::laneResult_t	queueMem [`RESULT_DEPTH];

	//////////////////////////////
	// Arbitration
	//////////////////////////////
	assign mltStall	= full;
	assign addStall	= full | mltValid;		// Loses to a multiply in the same cycle

	// Units only present when not stalled, so a push always has room
	assign push		= mltValid | addValid;
	assign pushData	= mltValid ? mltResult : addResult;
	assign popQ		= pop & ~empty;

	always_ff @(posedge clock) begin
		if (push)
			queueMem[wAddr] <= pushData;
	end

	assign head = queueMem[rAddr];

	ringBuffCtrl #(
		.numEntry	(`RESULT_DEPTH)
	) queueCtrl (
		.clock		(clock),
		.reset		(reset),
		.we			(push),
		.re			(popQ),
		.wAddr		(wAddr),
		.rAddr		(rAddr),
		.full		(full),
		.empty		(empty),
		.count		(count)
	);

endmodule

/* ringBuffCtrl.sv */
// Ring buffer controller
// Wrapping read and write pointers with occupancy count and flags

`timescale 1ns/1ns

module ringBuffCtrl #(
	parameter int numEntry = 4
) (
	input  logic							clock,
	input  logic							reset,
	input  logic							we,
	input  logic							re,
	output logic [$clog2(numEntry)-1:0]		wAddr,
	output logic [$clog2(numEntry)-1:0]		rAddr,
	output logic							full,
	output logic							empty,
	output logic [$clog2(numEntry+1)-1:0]	count
);

	localparam int addrWidth	= $clog2(numEntry);
	localparam int countWidth	= $clog2(numEntry+1);

	logic doWrite;
	logic doRead;

	// Wrap at numEntry, which need not be a power of two
	function automatic logic [addrWidth-1:0] nextPtr(input logic [addrWidth-1:0] ptr);
		logic [addrWidth-1:0] wrapped;
		wrapped = (ptr == addrWidth'(numEntry-1)) ? '0 : ptr + 1'b1;
		return wrapped;
	endfunction

	assign doWrite	= we & ~full;		// Overflow dropped
	assign doRead	= re & ~empty;

	assign full		= (count == countWidth'(numEntry));
	assign empty	= (count == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			wAddr	<= '0;
			rAddr	<= '0;
			count	<= '0;
		end else begin
			if (doWrite)
				wAddr <= nextPtr(wAddr);
			if (doRead)
				rAddr <= nextPtr(rAddr);
			case ({doWrite, doRead})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;		// Idle or both at once
			endcase
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the BLAS lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f blasLane.f \
	--top-module blasLaneTb -o blasLaneSim

simStatus=0
./obj_dir/blasLaneSim > sim.log 2>&1 || simStatus=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi
exit 0
